//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_core_top
FLIST      ?= flist.f
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+hw
hw/core_pkg.sv
hw/dec_ex_if.sv
hw/inst_decode.sv
hw/alu_execute.sv
hw/reg_file.sv
hw/core_top.sv
testbench/tb_core_top.sv

//--- hw/alu_execute.sv
`timescale 1ns/1ps
`include "core_config.svh"

module alu_execute (
  input  logic                    clk,
  input  logic                    reset_i,
  dec_ex_if.ex                    ex_i,
  output logic                    ex_fwd_valid_o,
  output logic [`CORE_REG_AW-1:0] ex_fwd_waddr_o,
  output logic [`CORE_XLEN-1:0]   ex_fwd_wdata_o,
  output logic                    wb_valid_o,
  output logic [`CORE_REG_AW-1:0] wb_waddr_o,
  output logic [`CORE_XLEN-1:0]   wb_wdata_o
);

  localparam int SH_W = $clog2(`CORE_XLEN);

  logic [SH_W-1:0]       shamt;
  logic                  lt_signed;
  logic                  lt_unsigned;
  logic [`CORE_XLEN-1:0] alu_res;

  assign shamt       = ex_i.opr1[SH_W-1:0];
  assign lt_signed   = $signed(ex_i.opr1) < $signed(ex_i.opr2);
  assign lt_unsigned = ex_i.opr1 < ex_i.opr2;

  always_comb begin
    case (ex_i.alu_op)
      `CORE_ALU_ADD:  alu_res = ex_i.opr1 + ex_i.opr2;
      `CORE_ALU_SUB:  alu_res = ex_i.opr1 - ex_i.opr2;
      `CORE_ALU_AND:  alu_res = ex_i.opr1 & ex_i.opr2;
      `CORE_ALU_OR:   alu_res = ex_i.opr1 | ex_i.opr2;
      `CORE_ALU_XOR:  alu_res = ex_i.opr1 ^ ex_i.opr2;
      `CORE_ALU_NOR:  alu_res = ~(ex_i.opr1 | ex_i.opr2);
      `CORE_ALU_SLT:  alu_res = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
      `CORE_ALU_SLTU: alu_res = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
      `CORE_ALU_SLL:  alu_res = ex_i.opr2 << shamt;
      `CORE_ALU_SRL:  alu_res = ex_i.opr2 >> shamt;
      `CORE_ALU_SRA:  alu_res = $signed(ex_i.opr2) >>> shamt;
      `CORE_ALU_LUI:  alu_res = {ex_i.opr2[15:0], {(`CORE_XLEN-16){1'b0}}};
      default:        alu_res = '0;
    endcase
  end

  // first forwarding source, straight off the alu
  assign ex_fwd_valid_o = ex_i.valid;
  assign ex_fwd_waddr_o = ex_i.waddr;
  assign ex_fwd_wdata_o = alu_res;

  always_ff @(posedge clk) begin
    if (reset_i)
      wb_valid_o <= 1'b0;
    else
      wb_valid_o <= ex_i.valid;
  end

  always_ff @(posedge clk) begin
    wb_waddr_o <= ex_i.waddr;
    wb_wdata_o <= alu_res;
  end

endmodule

//--- hw/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN       32
`define CORE_REG_AW     5
`define CORE_REG_NUM    32
`define CORE_ALU_OP_W   4

// alu operations
`define CORE_ALU_ADD    4'd0
`define CORE_ALU_SUB    4'd1
`define CORE_ALU_AND    4'd2
`define CORE_ALU_OR     4'd3
`define CORE_ALU_XOR    4'd4
`define CORE_ALU_NOR    4'd5
`define CORE_ALU_SLT    4'd6
`define CORE_ALU_SLTU   4'd7
`define CORE_ALU_SLL    4'd8
`define CORE_ALU_SRL    4'd9
`define CORE_ALU_SRA    4'd10
`define CORE_ALU_LUI    4'd11

// primary opcodes, mips32
`define CORE_OP_SPECIAL 6'h00
`define CORE_OP_ADDIU   6'h09
`define CORE_OP_SLTI    6'h0a
`define CORE_OP_SLTIU   6'h0b
`define CORE_OP_ANDI    6'h0c
`define CORE_OP_ORI     6'h0d
`define CORE_OP_XORI    6'h0e
`define CORE_OP_LUI     6'h0f

// special funct field
`define CORE_FN_SLL     6'h00
`define CORE_FN_SRL     6'h02
`define CORE_FN_SRA     6'h03
`define CORE_FN_ADDU    6'h21
`define CORE_FN_SUBU    6'h23
`define CORE_FN_AND     6'h24
`define CORE_FN_OR      6'h25
`define CORE_FN_XOR     6'h26
`define CORE_FN_NOR     6'h27
`define CORE_FN_SLT     6'h2a
`define CORE_FN_SLTU    6'h2b

`endif

//--- hw/core_pkg.sv
`include "core_config.svh"

package core_pkg;

  // register format, used by special opcode
  typedef struct packed {
    logic [5:0]              opcode;
    logic [`CORE_REG_AW-1:0] rs;
    logic [`CORE_REG_AW-1:0] rt;
    logic [`CORE_REG_AW-1:0] rd;
    logic [4:0]              shamt;
    logic [5:0]              funct;
  } r_fmt_t;

  // immediate format
  typedef struct packed {
    logic [5:0]              opcode;
    logic [`CORE_REG_AW-1:0] rs;
    logic [`CORE_REG_AW-1:0] rt;
    logic [15:0]             imm;
  } i_fmt_t;

  // same word, two views; decoder picks by opcode
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_t;

endpackage

//--- hw/core_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module core_top import core_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    inst_valid_i,
  input  inst_t                   inst_i,
  output logic                    debug_wb_rf_wen_o,
  output logic [`CORE_REG_AW-1:0] debug_wb_rf_wnum_o,
  output logic [`CORE_XLEN-1:0]   debug_wb_rf_wdata_o
);

  logic [`CORE_REG_AW-1:0] rf_raddr1;
  logic [`CORE_REG_AW-1:0] rf_raddr2;
  logic [`CORE_XLEN-1:0]   rf_rdata1;
  logic [`CORE_XLEN-1:0]   rf_rdata2;
  logic                    ex_fwd_valid;
  logic [`CORE_REG_AW-1:0] ex_fwd_waddr;
  logic [`CORE_XLEN-1:0]   ex_fwd_wdata;
  logic                    wb_valid;
  logic [`CORE_REG_AW-1:0] wb_waddr;
  logic [`CORE_XLEN-1:0]   wb_wdata;

  dec_ex_if dec_ex ();

  inst_decode i_decode (
    .clk            (clk),
    .reset_i        (reset_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .rf_raddr1_o    (rf_raddr1),
    .rf_raddr2_o    (rf_raddr2),
    .rf_rdata1_i    (rf_rdata1),
    .rf_rdata2_i    (rf_rdata2),
    .ex_fwd_valid_i (ex_fwd_valid),
    .ex_fwd_waddr_i (ex_fwd_waddr),
    .ex_fwd_wdata_i (ex_fwd_wdata),
    .wb_valid_i     (wb_valid),
    .wb_waddr_i     (wb_waddr),
    .wb_wdata_i     (wb_wdata),
    .dec_o          (dec_ex.dec)
  );

  alu_execute i_execute (
    .clk            (clk),
    .reset_i        (reset_i),
    .ex_i           (dec_ex.ex),
    .ex_fwd_valid_o (ex_fwd_valid),
    .ex_fwd_waddr_o (ex_fwd_waddr),
    .ex_fwd_wdata_o (ex_fwd_wdata),
    .wb_valid_o     (wb_valid),
    .wb_waddr_o     (wb_waddr),
    .wb_wdata_o     (wb_wdata)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr1_i (rf_raddr1),
    .raddr2_i (rf_raddr2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .wen_i    (wb_valid),
    .waddr_i  (wb_waddr),
    .wdata_i  (wb_wdata)
  );

  // debug port mirrors the regfile write
  assign debug_wb_rf_wen_o   = wb_valid;
  assign debug_wb_rf_wnum_o  = wb_waddr;
  assign debug_wb_rf_wdata_o = wb_wdata;

endmodule

//--- hw/dec_ex_if.sv
`timescale 1ns/1ps
`include "core_config.svh"

interface dec_ex_if;

  logic                      valid;
  logic [`CORE_ALU_OP_W-1:0] alu_op;
  logic [`CORE_XLEN-1:0]     opr1;   // shift amount for shifts
  logic [`CORE_XLEN-1:0]     opr2;
  logic [`CORE_REG_AW-1:0]   waddr;

  modport dec (
    output valid,
    output alu_op,
    output opr1,
    output opr2,
    output waddr
  );

  modport ex (
    input valid,
    input alu_op,
    input opr1,
    input opr2,
    input waddr
  );

endinterface

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`include "core_config.svh"

module inst_decode import core_pkg::*; (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      inst_valid_i,
  input  inst_t                     inst_i,
  output logic [`CORE_REG_AW-1:0]   rf_raddr1_o,
  output logic [`CORE_REG_AW-1:0]   rf_raddr2_o,
  input  logic [`CORE_XLEN-1:0]     rf_rdata1_i,
  input  logic [`CORE_XLEN-1:0]     rf_rdata2_i,
  input  logic                      ex_fwd_valid_i,
  input  logic [`CORE_REG_AW-1:0]   ex_fwd_waddr_i,
  input  logic [`CORE_XLEN-1:0]     ex_fwd_wdata_i,
  input  logic                      wb_valid_i,
  input  logic [`CORE_REG_AW-1:0]   wb_waddr_i,
  input  logic [`CORE_XLEN-1:0]     wb_wdata_i,
  dec_ex_if.dec                     dec_o
);

  logic                      is_rtype;
  logic                      supported;
  logic                      is_shift;
  logic                      imm_sext;
  logic [`CORE_ALU_OP_W-1:0] alu_op;
  logic [`CORE_REG_AW-1:0]   waddr;
  logic [`CORE_XLEN-1:0]     rs_val;
  logic [`CORE_XLEN-1:0]     rt_val;
  logic [`CORE_XLEN-1:0]     imm_ext;
  logic [`CORE_XLEN-1:0]     opr1;
  logic [`CORE_XLEN-1:0]     opr2;

  // newest value wins: execute, then result stage, then regfile
  function automatic logic [`CORE_XLEN-1:0] resolve(
    input logic [`CORE_REG_AW-1:0] addr,
    input logic [`CORE_XLEN-1:0]   rf_data
  );
    if (addr == '0)
      return '0;
    else if (ex_fwd_valid_i && ex_fwd_waddr_i == addr)
      return ex_fwd_wdata_i;
    else if (wb_valid_i && wb_waddr_i == addr)
      return wb_wdata_i;
    else
      return rf_data;
  endfunction

  assign is_rtype    = inst_i.r.opcode == `CORE_OP_SPECIAL;
  assign rf_raddr1_o = inst_i.i.rs;
  assign rf_raddr2_o = inst_i.i.rt;
  assign waddr       = is_rtype ? inst_i.r.rd : inst_i.i.rt;

  always_comb begin
    supported = 1'b1;
    is_shift  = 1'b0;
    imm_sext  = 1'b0;
    alu_op    = `CORE_ALU_ADD;
    if (is_rtype) begin
      case (inst_i.r.funct)
        `CORE_FN_ADDU: alu_op = `CORE_ALU_ADD;
        `CORE_FN_SUBU: alu_op = `CORE_ALU_SUB;
        `CORE_FN_AND:  alu_op = `CORE_ALU_AND;
        `CORE_FN_OR:   alu_op = `CORE_ALU_OR;
        `CORE_FN_XOR:  alu_op = `CORE_ALU_XOR;
        `CORE_FN_NOR:  alu_op = `CORE_ALU_NOR;
        `CORE_FN_SLT:  alu_op = `CORE_ALU_SLT;
        `CORE_FN_SLTU: alu_op = `CORE_ALU_SLTU;
        `CORE_FN_SLL: begin alu_op = `CORE_ALU_SLL; is_shift = 1'b1; end
        `CORE_FN_SRL: begin alu_op = `CORE_ALU_SRL; is_shift = 1'b1; end
        `CORE_FN_SRA: begin alu_op = `CORE_ALU_SRA; is_shift = 1'b1; end
        default:       supported = 1'b0;
      endcase
    end else begin
      case (inst_i.i.opcode)
        `CORE_OP_ADDIU: begin alu_op = `CORE_ALU_ADD;  imm_sext = 1'b1; end
        `CORE_OP_SLTI:  begin alu_op = `CORE_ALU_SLT;  imm_sext = 1'b1; end
        `CORE_OP_SLTIU: begin alu_op = `CORE_ALU_SLTU; imm_sext = 1'b1; end
        `CORE_OP_ANDI:  alu_op = `CORE_ALU_AND;
        `CORE_OP_ORI:   alu_op = `CORE_ALU_OR;
        `CORE_OP_XORI:  alu_op = `CORE_ALU_XOR;
        `CORE_OP_LUI:   alu_op = `CORE_ALU_LUI;
        default:        supported = 1'b0;
      endcase
    end
  end

  always_comb begin
    rs_val = resolve(rf_raddr1_o, rf_rdata1_i);
    rt_val = resolve(rf_raddr2_o, rf_rdata2_i);
  end

  // sltiu compares against the sign-extended immediate too
  assign imm_ext = imm_sext ? {{(`CORE_XLEN-16){inst_i.i.imm[15]}}, inst_i.i.imm}
                            : {{(`CORE_XLEN-16){1'b0}}, inst_i.i.imm};

  always_comb begin
    if (is_shift) begin
      opr1 = {{(`CORE_XLEN-5){1'b0}}, inst_i.r.shamt};
      opr2 = rt_val;
    end else begin
      opr1 = rs_val;
      opr2 = is_rtype ? rt_val : imm_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i)
      dec_o.valid <= 1'b0;
    else
      dec_o.valid <= inst_valid_i && supported && waddr != '0; // r0 writes retire silently
  end

  always_ff @(posedge clk) begin
    dec_o.alu_op <= alu_op;
    dec_o.opr1   <= opr1;
    dec_o.opr2   <= opr2;
    dec_o.waddr  <= waddr;
  end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "core_config.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic [`CORE_REG_AW-1:0] raddr1_i,
  input  logic [`CORE_REG_AW-1:0] raddr2_i,
  output logic [`CORE_XLEN-1:0]   rdata1_o,
  output logic [`CORE_XLEN-1:0]   rdata2_o,
  input  logic                    wen_i,
  input  logic [`CORE_REG_AW-1:0] waddr_i,
  input  logic [`CORE_XLEN-1:0]   wdata_i
);

  logic [`CORE_XLEN-1:0] regs [`CORE_REG_NUM];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `CORE_REG_NUM; i++)
        regs[i] <= '0;
    end else if (wen_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // no write-through here, decode forwards from the result stage
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

//--- testbench/tb_core_top.sv
`timescale 1ns/1ps
`include "core_config.svh"

module tb_core_top import core_pkg::*; ();

  typedef logic [`CORE_REG_AW-1:0] reg_addr_t;
  typedef logic [`CORE_XLEN-1:0]   data_t;

  localparam int N_CYCLES   = 2000;
  localparam int RST_CYCLES = 4;
  localparam int IDLE_START = 8;
  localparam int MAX_CYCLES = N_CYCLES + RST_CYCLES + 50;

  localparam logic [5:0] R_FN [11] = '{`CORE_FN_ADDU, `CORE_FN_SUBU, `CORE_FN_AND,
                                       `CORE_FN_OR, `CORE_FN_XOR, `CORE_FN_NOR,
                                       `CORE_FN_SLT, `CORE_FN_SLTU, `CORE_FN_SLL,
                                       `CORE_FN_SRL, `CORE_FN_SRA};
  localparam logic [5:0] I_OP [7]  = '{`CORE_OP_ADDIU, `CORE_OP_SLTI, `CORE_OP_SLTIU,
                                       `CORE_OP_ANDI, `CORE_OP_ORI, `CORE_OP_XORI,
                                       `CORE_OP_LUI};
  localparam logic [5:0] BAD_FN [3] = '{6'h01, 6'h08, 6'h20}; // movci, jr, add
  localparam logic [5:0] BAD_OP [3] = '{6'h02, 6'h08, 6'h23}; // j, addi, lw

  logic      clk;
  logic      reset_i;
  logic      inst_valid_i;
  inst_t     inst_i;
  logic      debug_wb_rf_wen_o;
  reg_addr_t debug_wb_rf_wnum_o;
  data_t     debug_wb_rf_wdata_o;

  data_t     model_regs [`CORE_REG_NUM];
  int        exp_cyc_q [$];   // cycle the write shows up on the debug port
  reg_addr_t exp_wnum_q [$];
  data_t     exp_wdata_q [$];
  int        seed;
  int        cyc = 0;

  core_top i_dut (
    .clk                 (clk),
    .reset_i             (reset_i),
    .inst_valid_i        (inst_valid_i),
    .inst_i              (inst_i),
    .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
    .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
    .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES)
      report_error($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic reg_addr_t pick_reg();
    return reg_addr_t'(rand_below(8)); // small range keeps hazards frequent
  endfunction

  task automatic gen_inst(output logic v, output inst_t w);
    int kind;
    v    = rand_below(100) < 80;
    kind = rand_below(100);
    w    = inst_t'($random(seed)); // random imm and shamt
    if (kind < 5) begin
      if (kind < 2) begin
        w.r.opcode = `CORE_OP_SPECIAL;
        w.r.funct  = BAD_FN[rand_below(3)];
      end else begin
        w.i.opcode = BAD_OP[rand_below(3)];
      end
    end else if (kind < 55) begin
      w.r.opcode = `CORE_OP_SPECIAL;
      w.r.funct  = R_FN[rand_below(11)];
    end else begin
      w.i.opcode = I_OP[rand_below(7)];
    end
    w.r.rs = pick_reg();
    w.r.rt = pick_reg();
    if (w.r.opcode == `CORE_OP_SPECIAL)
      w.r.rd = pick_reg();
  endtask

  // architectural model updated in program order at issue
  task automatic model_issue(input logic v, input inst_t w);
    data_t     a;
    data_t     b;
    data_t     sext;
    data_t     zext;
    data_t     res;
    reg_addr_t dest;
    logic      ok;
    ok   = 1'b1;
    res  = '0;
    a    = model_regs[w.r.rs];
    b    = model_regs[w.r.rt];
    sext = {{(`CORE_XLEN-16){w.i.imm[15]}}, w.i.imm};
    zext = {{(`CORE_XLEN-16){1'b0}}, w.i.imm};
    if (w.r.opcode == `CORE_OP_SPECIAL) begin
      dest = w.r.rd;
      case (w.r.funct)
        `CORE_FN_ADDU: res = a + b;
        `CORE_FN_SUBU: res = a - b;
        `CORE_FN_AND:  res = a & b;
        `CORE_FN_OR:   res = a | b;
        `CORE_FN_XOR:  res = a ^ b;
        `CORE_FN_NOR:  res = ~(a | b);
        `CORE_FN_SLT:  res = ($signed(a) < $signed(b)) ? data_t'(1) : '0;
        `CORE_FN_SLTU: res = (a < b) ? data_t'(1) : '0;
        `CORE_FN_SLL:  res = b << w.r.shamt;
        `CORE_FN_SRL:  res = b >> w.r.shamt;
        `CORE_FN_SRA:  res = data_t'($signed(b) >>> w.r.shamt);
        default:       ok = 1'b0;
      endcase
    end else begin
      dest = w.i.rt;
      case (w.i.opcode)
        `CORE_OP_ADDIU: res = a + sext;
        `CORE_OP_SLTI:  res = ($signed(a) < $signed(sext)) ? data_t'(1) : '0;
        `CORE_OP_SLTIU: res = (a < sext) ? data_t'(1) : '0;
        `CORE_OP_ANDI:  res = a & zext;
        `CORE_OP_ORI:   res = a | zext;
        `CORE_OP_XORI:  res = a ^ zext;
        `CORE_OP_LUI:   res = {w.i.imm, {(`CORE_XLEN-16){1'b0}}};
        default:        ok = 1'b0;
      endcase
    end
    if (v && ok && dest != '0) begin
      model_regs[dest] = res;
      exp_cyc_q.push_back(cyc + 2);
      exp_wnum_q.push_back(dest);
      exp_wdata_q.push_back(res);
    end
  endtask

  task automatic check_wnum(input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      report_error($sformatf("error: debug_wb_rf_wnum_o = %h, expected %h", got, exp));
  endtask

  task automatic check_wdata(input data_t got, input data_t exp);
    if (got !== exp)
      report_error($sformatf("error: debug_wb_rf_wdata_o = %h, expected %h", got, exp));
  endtask

  task automatic check_cycle();
    logic exp_wen;
    exp_wen = exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc;
    if (exp_wen && debug_wb_rf_wen_o !== 1'b1)
      report_error($sformatf("missing write to register %0d at cycle %0d",
                             exp_wnum_q[0], cyc));
    else if (!exp_wen && debug_wb_rf_wen_o !== 1'b0)
      report_error($sformatf("unexpected register write at cycle %0d", cyc));
    if (exp_wen) begin
      check_wnum(debug_wb_rf_wnum_o, exp_wnum_q[0]);
      check_wdata(debug_wb_rf_wdata_o, exp_wdata_q[0]);
      void'(exp_cyc_q.pop_front());
      void'(exp_wnum_q.pop_front());
      void'(exp_wdata_q.pop_front());
    end
  endtask

  task automatic drive_cycle(input logic v, input inst_t w);
    @(posedge clk);
    #1;
    inst_valid_i = v;
    inst_i       = w;
    model_issue(v, w);
    @(negedge clk); // outputs settled mid-cycle
    check_cycle();
  endtask

  initial begin
    logic  v;
    inst_t w;
    seed         = 1;
    reset_i      = 1'b1;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    for (int r = 0; r < `CORE_REG_NUM; r++)
      model_regs[r] = '0;

    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge clk);
      #1;
      if (i == RST_CYCLES - 1)
        reset_i = 1'b0;
      @(negedge clk);
      check_cycle();
    end

    repeat (IDLE_START)
      drive_cycle(1'b0, '0);

    for (int n = 0; n < N_CYCLES; n++) begin
      gen_inst(v, w);
      drive_cycle(v, w);
    end

    // drain the pipe, then a few quiet cycles
    while (exp_cyc_q.size() > 0)
      drive_cycle(1'b0, '0);
    repeat (4)
      drive_cycle(1'b0, '0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
